// File: common/vstq_defines.svh
// Queue sizes; BANKS and ENTRIES must be powers of two, DLEN_W a multiple of 8
`ifndef VSTQ_DEFINES_SVH
`define VSTQ_DEFINES_SVH

`define VSTQ_BANKS    2
`define VSTQ_ENTRIES  4

`define VSTQ_PADDR_W  32
`define VSTQ_DLEN_W   128
`define VSTQ_ID_W     5     // Index bits plus wrap bit

`define VSTQ_VREG_N   8
`define VSTQ_POS_W    1     // Two lines per register

`endif

// File: common/vstq_pkg.sv
// Ids carry a wrap bit on top; age compares hold only within half the id space
`include "vstq_defines.svh"

package vstq_pkg;

  localparam int PADDR_W  = `VSTQ_PADDR_W;
  localparam int ID_W     = `VSTQ_ID_W;
  localparam int BANK_W   = $clog2(`VSTQ_BANKS);
  localparam int ENT_W    = $clog2(`VSTQ_ENTRIES);
  localparam int BANK_LSB = $clog2(`VSTQ_DLEN_W / 8);  // Byte offset in a line
  localparam int LINE_LSB = BANK_LSB + BANK_W;
  localparam int WB_ADR_W = PADDR_W - BANK_LSB;

  typedef logic [ID_W-1:0]                 cmt_id_t;
  typedef logic [PADDR_W-1:0]              paddr_t;
  typedef logic [PADDR_W-1:LINE_LSB]       line_addr_t;
  typedef logic [`VSTQ_DLEN_W-1:0]         dlen_data_t;
  typedef logic [`VSTQ_DLEN_W/8-1:0]       dlen_strb_t;
  typedef logic [$clog2(`VSTQ_VREG_N)-1:0] vreg_idx_t;
  typedef logic [`VSTQ_POS_W-1:0]          vec_pos_t;

  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [ENT_W-1:0]  idx;
  } entry_tag_t;

  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    WAIT_COMMIT = 3'd1,
    READ_VS3    = 3'd2,
    DRAIN       = 3'd3,
    FINISH      = 3'd4
  } vstq_state_t;

  typedef struct packed {
    cmt_id_t    cmt_id;
    vreg_idx_t  vs3_idx;
    vec_pos_t   vs3_pos;
    dlen_strb_t strb;
    line_addr_t line_addr;
  } vstq_entry_t;

  typedef struct packed {
    vstq_entry_t      entry;
    logic [ENT_W-1:0] idx;
  } vstq_cand_t;

  // True when id0 is older than id1
  function automatic logic id_is_older(cmt_id_t id0, cmt_id_t id1);
    logic wrapped;
    wrapped = id0[ID_W-1] ^ id1[ID_W-1];
    return wrapped ? (id0[ID_W-2:0] > id1[ID_W-2:0]) : (id0[ID_W-2:0] < id1[ID_W-2:0]);
  endfunction

endpackage

// File: common/vstq_ifs.sv
// Source must hold alloc fields stable while valid; vs3 data follows a read by one cycle
`timescale 1ns/10ps

interface vstq_alloc_if
  import vstq_pkg::*;
();
  logic       valid;
  logic       ready;
  cmt_id_t    cmt_id;
  vreg_idx_t  vs3_idx;
  vec_pos_t   vs3_pos;
  dlen_strb_t strb;
  paddr_t     paddr;

  modport src (
    output valid, cmt_id, vs3_idx, vs3_pos, strb, paddr,
    input  ready
  );
  modport dst (
    input  valid, cmt_id, vs3_idx, vs3_pos, strb, paddr,
    output ready
  );
endinterface

interface vs3_rd_if
  import vstq_pkg::*;
();
  logic       valid;
  vreg_idx_t  idx;
  vec_pos_t   pos;
  dlen_data_t data;   // Valid one cycle after the request

  modport req (output valid, idx, pos, input  data);
  modport rsp (input  valid, idx, pos, output data);
endinterface

// File: source/rr_select.sv
// WIDTH must be at least 2; the pointer moves only when i_advance is high with a request
`timescale 1ns/10ps

module rr_select #(
  parameter int  WIDTH = 4,
  parameter type T     = logic
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic [WIDTH-1:0] i_req,
  input  logic             i_advance,
  input  T                 i_data [WIDTH],
  output logic [WIDTH-1:0] o_grant,
  output logic             o_any,
  output T                 o_sel
);

  localparam int IDX_W = $clog2(WIDTH);

  logic [IDX_W-1:0] r_last;
  logic [IDX_W-1:0] w_next;

  assign o_any = |i_req;

  // Scan from the far end so the nearest requester after r_last wins
  always_comb begin
    int idx;
    o_grant = '0;
    w_next  = r_last;
    for (int i = WIDTH; i >= 1; i--) begin
      idx = (int'(r_last) + i) % WIDTH;
      if (i_req[idx]) begin
        o_grant = WIDTH'(1) << idx;
        w_next  = IDX_W'(idx);
      end
    end
  end

  always_comb begin
    o_sel = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (o_grant[i]) o_sel = i_data[i];
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last <= IDX_W'(WIDTH - 1);
    end else if (i_advance && o_any) begin
      r_last <= w_next;
    end
  end

endmodule

// File: source/freelist_oh.sv
// Offers the lowest free entry; the caller must not pop while o_full is high
`timescale 1ns/10ps

module freelist_oh #(
  parameter int WIDTH = 4
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_pop_oh,
  input  logic [WIDTH-1:0] i_push_oh,
  output logic             o_full
);

  logic [WIDTH-1:0] r_free;

  assign o_pop_oh = r_free & (~r_free + WIDTH'(1));  // Lowest set bit
  assign o_full   = ~|r_free;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_free <= '1;
    end else begin
      r_free <= (r_free & ~(o_pop_oh & {WIDTH{i_pop}})) | i_push_oh;
    end
  end

endmodule

// File: source/vec_regfile.sv
// Read data is registered and held until the next read; a same-line write returns old data
`timescale 1ns/10ps
`include "vstq_defines.svh"

module vec_regfile
  import vstq_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_we,
  input  vreg_idx_t  i_widx,
  input  vec_pos_t   i_wpos,
  input  dlen_data_t i_wdata,
  vs3_rd_if.rsp      rd
);

  localparam int LINES = 1 << `VSTQ_POS_W;

  dlen_data_t r_mem [`VSTQ_VREG_N][LINES];
  dlen_data_t r_rdata;

  always_ff @(posedge i_clk) begin
    if (i_we) r_mem[i_widx][i_wpos] <= i_wdata;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rdata <= '0;
    end else if (rd.valid) begin
      r_rdata <= r_mem[rd.idx][rd.pos];
    end
  end

  assign rd.data = r_rdata;

endmodule

// File: vstq/vstq_bank.sv
// Entries of one bank; one commit id per cycle, flush only acts on uncommitted entries
`timescale 1ns/10ps
`include "vstq_defines.svh"

module vstq_bank
  import vstq_pkg::*;
#(
  parameter int BANK_IDX = 0
) (
  input  logic        i_clk,
  input  logic        i_reset_n,

  input  logic        i_alloc_valid,
  input  vstq_entry_t i_alloc_entry,
  output logic        o_full,

  input  logic        i_commit_valid,
  input  cmt_id_t     i_commit_id,
  input  logic        i_commit_flush,
  input  logic        i_br_valid,
  input  cmt_id_t     i_br_id,

  input  logic        i_grant_take,
  output logic        o_cand_valid,
  output vstq_cand_t  o_cand,

  input  logic        i_done_valid,
  input  entry_tag_t  i_done_idx,

  input  logic        i_ld_valid,
  input  cmt_id_t     i_ld_id,
  input  line_addr_t  i_ld_line,
  output logic        o_haz
);

  localparam int N = `VSTQ_ENTRIES;

  vstq_state_t  r_state [N];
  vstq_entry_t  r_entry [N];
  logic [N-1:0] w_alloc_oh;
  logic [N-1:0] w_finish;
  logic [N-1:0] w_read_req;
  logic [N-1:0] w_grant;
  logic [N-1:0] w_hit;
  logic         w_done_here;
  vstq_entry_t  w_sel_entry;

  assign w_done_here = i_done_valid && (i_done_idx.bank == BANK_W'(BANK_IDX));

  freelist_oh #(.WIDTH(N)) u_freelist (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_pop     (i_alloc_valid),
    .o_pop_oh  (w_alloc_oh),
    .i_push_oh (w_finish),
    .o_full    (o_full)
  );

  // ------------------------------------------------------------------
  // Per-entry state
  // ------------------------------------------------------------------
  for (genvar e = 0; e < N; e++) begin : g_entry
    logic w_load;
    logic w_kill;

    assign w_load = i_alloc_valid && w_alloc_oh[e];
    assign w_kill = (i_commit_valid && i_commit_flush) ||
                    (i_br_valid && id_is_older(i_br_id, r_entry[e].cmt_id));

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state[e] <= IDLE;
      end else begin
        case (r_state[e])
          IDLE: begin
            if (w_load) r_state[e] <= WAIT_COMMIT;
          end
          WAIT_COMMIT: begin
            if (w_kill) begin
              r_state[e] <= FINISH;
            end else if (i_commit_valid && i_commit_id == r_entry[e].cmt_id) begin
              r_state[e] <= READ_VS3;
            end
          end
          READ_VS3: begin
            if (i_grant_take && w_grant[e]) r_state[e] <= DRAIN;
          end
          DRAIN: begin
            if (w_done_here && i_done_idx.idx == ENT_W'(e)) r_state[e] <= FINISH;
          end
          default: r_state[e] <= IDLE;  // FINISH returns the slot
        endcase
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_load) r_entry[e] <= i_alloc_entry;
    end

    assign w_finish[e]   = r_state[e] == FINISH;
    assign w_read_req[e] = r_state[e] == READ_VS3;

    // Older store to the same line still pending
    assign w_hit[e] = (r_state[e] inside {WAIT_COMMIT, READ_VS3, DRAIN}) &&
                      id_is_older(r_entry[e].cmt_id, i_ld_id) &&
                      (r_entry[e].line_addr == i_ld_line);
  end

  assign o_haz = i_ld_valid && |w_hit;

  // ------------------------------------------------------------------
  // Local read arbiter
  // ------------------------------------------------------------------
  rr_select #(.WIDTH(N), .T(vstq_entry_t)) u_entry_arb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (w_read_req),
    .i_advance (i_grant_take),
    .i_data    (r_entry),
    .o_grant   (w_grant),
    .o_any     (o_cand_valid),
    .o_sel     (w_sel_entry)
  );

  always_comb begin
    o_cand.entry = w_sel_entry;
    o_cand.idx   = '0;
    for (int e = 0; e < N; e++) begin
      if (w_grant[e]) o_cand.idx = ENT_W'(e);
    end
  end

endmodule

// File: vstq/vstq.sv
// Two lines in flight at most; Wishbone address is the line address, bank bit included
`timescale 1ns/10ps
`include "vstq_defines.svh"

module vstq
  import vstq_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  vstq_alloc_if.dst           alloc,
  input  logic                i_commit_valid,
  input  cmt_id_t             i_commit_id,
  input  logic                i_commit_flush,
  input  logic                i_br_valid,
  input  cmt_id_t             i_br_id,
  input  logic                i_ld_valid,
  input  cmt_id_t             i_ld_id,
  input  paddr_t              i_ld_paddr,
  vs3_rd_if.req               vs3,
  output logic                o_ld_haz,
  output logic                o_wb_cyc,
  output logic                o_wb_stb,
  output logic                o_wb_we,
  output logic [WB_ADR_W-1:0] o_wb_adr,
  output dlen_data_t          o_wb_dat,
  output dlen_strb_t          o_wb_sel,
  input  logic                i_wb_ack
);

  localparam int NB = `VSTQ_BANKS;

  logic              r_alive;
  logic [BANK_W-1:0] w_alloc_bank;
  vstq_entry_t       w_alloc_entry;
  logic [NB-1:0]     w_full;
  logic [NB-1:0]     w_cand_valid;
  logic [NB-1:0]     w_bank_grant;
  logic [NB-1:0]     w_haz;
  vstq_cand_t        w_cand [NB];
  vstq_cand_t        w_win;
  entry_tag_t        w_win_tag;
  logic              w_any;
  logic              w_issue;
  logic              w_rd_free;
  logic              w_wb_free;

  logic              r_rd_valid;
  entry_tag_t        r_rd_tag;
  dlen_strb_t        r_rd_strb;
  line_addr_t        r_rd_line;
  logic              r_wb_valid;
  entry_tag_t        r_wb_tag;

  // ------------------------------------------------------------------
  // Allocation steering
  // ------------------------------------------------------------------
  assign w_alloc_bank  = alloc.paddr[BANK_LSB +: BANK_W];
  assign w_alloc_entry = '{cmt_id:    alloc.cmt_id,
                           vs3_idx:   alloc.vs3_idx,
                           vs3_pos:   alloc.vs3_pos,
                           strb:      alloc.strb,
                           line_addr: alloc.paddr[PADDR_W-1:LINE_LSB]};
  assign alloc.ready   = r_alive && !w_full[w_alloc_bank];

  for (genvar b = 0; b < NB; b++) begin : g_bank
    vstq_bank #(.BANK_IDX(b)) u_bank (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_alloc_valid  (alloc.valid && alloc.ready && (w_alloc_bank == BANK_W'(b))),
      .i_alloc_entry  (w_alloc_entry),
      .o_full         (w_full[b]),
      .i_commit_valid (i_commit_valid),
      .i_commit_id    (i_commit_id),
      .i_commit_flush (i_commit_flush),
      .i_br_valid     (i_br_valid),
      .i_br_id        (i_br_id),
      .i_grant_take   (w_issue && w_bank_grant[b]),
      .o_cand_valid   (w_cand_valid[b]),
      .o_cand         (w_cand[b]),
      .i_done_valid   (r_wb_valid && i_wb_ack),
      .i_done_idx     (r_wb_tag),
      .i_ld_valid     (i_ld_valid && (i_ld_paddr[BANK_LSB +: BANK_W] == BANK_W'(b))),
      .i_ld_id        (i_ld_id),
      .i_ld_line      (i_ld_paddr[PADDR_W-1:LINE_LSB]),
      .o_haz          (w_haz[b])
    );
  end

  assign o_ld_haz = |w_haz;

  // ------------------------------------------------------------------
  // Bank arbitration and vs3 read
  // ------------------------------------------------------------------
  rr_select #(.WIDTH(NB), .T(vstq_cand_t)) u_bank_arb (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (w_cand_valid),
    .i_advance (w_issue),
    .i_data    (w_cand),
    .o_grant   (w_bank_grant),
    .o_any     (w_any),
    .o_sel     (w_win)
  );

  always_comb begin
    w_win_tag.idx  = w_win.idx;
    w_win_tag.bank = '0;
    for (int b = 0; b < NB; b++) begin
      if (w_bank_grant[b]) w_win_tag.bank = BANK_W'(b);
    end
  end

  assign w_wb_free = !r_wb_valid || i_wb_ack;
  assign w_rd_free = !r_rd_valid || w_wb_free;
  assign w_issue   = w_any && w_rd_free;   // Regfile output holds while read stage waits

  assign vs3.valid = w_issue;
  assign vs3.idx   = w_win.entry.vs3_idx;
  assign vs3.pos   = w_win.entry.vs3_pos;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alive    <= 1'b0;
      r_rd_valid <= 1'b0;
      r_wb_valid <= 1'b0;
    end else begin
      r_alive <= 1'b1;
      if (w_rd_free) r_rd_valid <= w_issue;
      if (w_wb_free) r_wb_valid <= r_rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue) begin
      r_rd_tag  <= w_win_tag;
      r_rd_strb <= w_win.entry.strb;
      r_rd_line <= w_win.entry.line_addr;
    end
    if (w_wb_free && r_rd_valid) begin
      r_wb_tag <= r_rd_tag;
      o_wb_adr <= {r_rd_line, r_rd_tag.bank};
      o_wb_dat <= vs3.data;
      o_wb_sel <= r_rd_strb;
    end
  end

  // Classic single write, held until ack
  assign o_wb_cyc = r_wb_valid;
  assign o_wb_stb = r_wb_valid;
  assign o_wb_we  = r_wb_valid;

endmodule

// File: source/vstq_subsystem.sv
// Store queue with its vs3 register file; the memory side is a Wishbone classic write master
`timescale 1ns/10ps

module vstq_subsystem
  import vstq_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_alloc_valid,
  output logic                o_alloc_ready,
  input  cmt_id_t             i_alloc_cmt_id,
  input  vreg_idx_t           i_alloc_vs3_idx,
  input  vec_pos_t            i_alloc_vs3_pos,
  input  dlen_strb_t          i_alloc_strb,
  input  paddr_t              i_alloc_paddr,

  input  logic                i_commit_valid,
  input  cmt_id_t             i_commit_id,
  input  logic                i_commit_flush,
  input  logic                i_br_valid,
  input  cmt_id_t             i_br_id,

  input  logic                i_vrf_we,
  input  vreg_idx_t           i_vrf_idx,
  input  vec_pos_t            i_vrf_pos,
  input  dlen_data_t          i_vrf_data,

  input  logic                i_ld_valid,
  input  cmt_id_t             i_ld_id,
  input  paddr_t              i_ld_paddr,
  output logic                o_ld_haz,

  output logic                o_wb_cyc,
  output logic                o_wb_stb,
  output logic                o_wb_we,
  output logic [WB_ADR_W-1:0] o_wb_adr,
  output dlen_data_t          o_wb_dat,
  output dlen_strb_t          o_wb_sel,
  input  logic                i_wb_ack
);

  vstq_alloc_if u_alloc_if ();
  vs3_rd_if     u_vs3_if ();

  assign u_alloc_if.valid   = i_alloc_valid;
  assign u_alloc_if.cmt_id  = i_alloc_cmt_id;
  assign u_alloc_if.vs3_idx = i_alloc_vs3_idx;
  assign u_alloc_if.vs3_pos = i_alloc_vs3_pos;
  assign u_alloc_if.strb    = i_alloc_strb;
  assign u_alloc_if.paddr   = i_alloc_paddr;
  assign o_alloc_ready      = u_alloc_if.ready;

  vstq u_vstq (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .alloc          (u_alloc_if.dst),
    .i_commit_valid (i_commit_valid),
    .i_commit_id    (i_commit_id),
    .i_commit_flush (i_commit_flush),
    .i_br_valid     (i_br_valid),
    .i_br_id        (i_br_id),
    .i_ld_valid     (i_ld_valid),
    .i_ld_id        (i_ld_id),
    .i_ld_paddr     (i_ld_paddr),
    .vs3            (u_vs3_if.req),
    .o_ld_haz       (o_ld_haz),
    .o_wb_cyc       (o_wb_cyc),
    .o_wb_stb       (o_wb_stb),
    .o_wb_we        (o_wb_we),
    .o_wb_adr       (o_wb_adr),
    .o_wb_dat       (o_wb_dat),
    .o_wb_sel       (o_wb_sel),
    .i_wb_ack       (i_wb_ack)
  );

  vec_regfile u_vrf (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_we      (i_vrf_we),
    .i_widx    (i_vrf_idx),
    .i_wpos    (i_vrf_pos),
    .i_wdata   (i_vrf_data),
    .rd        (u_vs3_if.rsp)
  );

endmodule

// File: test/tb_clkgen.sv
// Free-running clock; reset releases 1 ns after the last of RESET_CYCLES rising edges
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset_n = 1'b1;
  end

endmodule

// File: test/tb_vstq.sv
// Memory model takes one write at a time with 0 to 3 wait cycles; ids stay below 16
`timescale 1ns/10ps

module tb_vstq
  import vstq_pkg::*;
();

  localparam int TIMEOUT = 400;   // Cycles per wait loop
  localparam int QUIET   = 16;    // Idle cycles that must show no extra write

  typedef enum int {
    OP_VRF, OP_ALLOC, OP_COMMIT, OP_CFLUSH, OP_BFLUSH,
    OP_LOAD, OP_READY, OP_DRAIN, OP_LINE
  } op_t;

  typedef struct {
    string      name;
    op_t        op;
    cmt_id_t    id;
    vreg_idx_t  vidx;
    vec_pos_t   vpos;
    dlen_strb_t strb;
    paddr_t     paddr;
    dlen_data_t data;      // Register data or expected line
    logic       exp_bit;   // Expected hazard or ready
    int         exp_cnt;   // Expected write count
  } row_t;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_alloc_valid;
  logic                o_alloc_ready;
  cmt_id_t             i_alloc_cmt_id;
  vreg_idx_t           i_alloc_vs3_idx;
  vec_pos_t            i_alloc_vs3_pos;
  dlen_strb_t          i_alloc_strb;
  paddr_t              i_alloc_paddr;
  logic                i_commit_valid;
  cmt_id_t             i_commit_id;
  logic                i_commit_flush;
  logic                i_br_valid;
  cmt_id_t             i_br_id;
  logic                i_vrf_we;
  vreg_idx_t           i_vrf_idx;
  vec_pos_t            i_vrf_pos;
  dlen_data_t          i_vrf_data;
  logic                i_ld_valid;
  cmt_id_t             i_ld_id;
  paddr_t              i_ld_paddr;
  logic                o_ld_haz;
  logic                o_wb_cyc;
  logic                o_wb_stb;
  logic                o_wb_we;
  logic [WB_ADR_W-1:0] o_wb_adr;
  dlen_data_t          o_wb_dat;
  dlen_strb_t          o_wb_sel;
  logic                i_wb_ack;

  dlen_data_t mem [logic [WB_ADR_W-1:0]];
  int         wr_cnt [logic [WB_ADR_W-1:0]];
  int         wr_total = 0;
  row_t       rows [$];

  tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(8)) u_clkgen (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  vstq_subsystem dut (.*);

  // ------------------------------------------------------------------
  // Line patterns and byte merge
  // ------------------------------------------------------------------
  function automatic dlen_data_t fill_line(logic [WB_ADR_W-1:0] adr);
    dlen_data_t line;
    for (int w = 0; w < $bits(dlen_data_t) / 32; w++) begin
      line[32*w +: 32] = {4'(w), adr} ^ 32'hA5C3_0F1E;
    end
    return line;
  endfunction

  function automatic dlen_data_t vrf_pattern(vreg_idx_t idx, vec_pos_t pos);
    dlen_data_t line;
    for (int w = 0; w < $bits(dlen_data_t) / 32; w++) begin
      line[32*w +: 32] = {8'(idx) ^ 8'hC6, 8'(pos) ^ 8'h39, 8'(w) ^ 8'h71,
                          8'(idx * 16 + w) ^ 8'hE4};
    end
    return line;
  endfunction

  function automatic dlen_data_t merge_bytes(dlen_data_t old, dlen_data_t upd, dlen_strb_t sel);
    dlen_data_t line;
    for (int b = 0; b < $bits(dlen_strb_t); b++) begin
      line[8*b +: 8] = sel[b] ? upd[8*b +: 8] : old[8*b +: 8];
    end
    return line;
  endfunction

  function automatic dlen_data_t read_line(logic [WB_ADR_W-1:0] adr);
    return mem.exists(adr) ? mem[adr] : fill_line(adr);
  endfunction

  function automatic int count_of(logic [WB_ADR_W-1:0] adr);
    return wr_cnt.exists(adr) ? wr_cnt[adr] : 0;
  endfunction

  // ------------------------------------------------------------------
  // Failure reporting and checks
  // ------------------------------------------------------------------
  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_line(string name, dlen_data_t exp, dlen_data_t act);
    if (act !== exp) begin
      report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_haz(string name, logic exp, logic act);
    if (act !== exp) begin
      report_fail($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp) begin
      report_fail($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      report_fail($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // ------------------------------------------------------------------
  // Wishbone slave with random wait states
  // ------------------------------------------------------------------
  initial begin : wb_slave
    logic [WB_ADR_W-1:0] adr;
    dlen_data_t          dat;
    dlen_strb_t          sel;
    logic                busy;
    int                  wait_n;
    void'($urandom(90129));
    busy     = 1'b0;
    wait_n   = 0;
    i_wb_ack = 1'b0;
    forever begin
      @(posedge i_clk);
      #1;
      if (i_wb_ack) begin          // Write taken at this edge
        i_wb_ack = 1'b0;
        busy     = 1'b0;
      end else if (busy) begin
        if (!o_wb_stb || o_wb_adr !== adr || o_wb_dat !== dat || o_wb_sel !== sel) begin
          report_fail("Wishbone request changed or dropped before its ack");
        end
      end
      if (!busy && o_wb_cyc && o_wb_stb) begin
        if (!o_wb_we) report_fail("Wishbone request came without write enable");
        adr    = o_wb_adr;
        dat    = o_wb_dat;
        sel    = o_wb_sel;
        busy   = 1'b1;
        wait_n = $urandom_range(3, 0);
      end
      if (busy && !i_wb_ack) begin
        if (wait_n == 0) begin
          mem[adr]    = merge_bytes(read_line(adr), dat, sel);
          wr_cnt[adr] = count_of(adr) + 1;
          wr_total++;
          i_wb_ack    = 1'b1;
        end else begin
          wait_n--;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Table of operations
  // ------------------------------------------------------------------
  task automatic add_row(string name, op_t op, cmt_id_t id, vreg_idx_t vidx,
                         vec_pos_t vpos, dlen_strb_t strb, paddr_t paddr,
                         logic exp_bit, int exp_cnt);
    row_t r;
    r.name    = name;
    r.op      = op;
    r.id      = id;
    r.vidx    = vidx;
    r.vpos    = vpos;
    r.strb    = strb;
    r.paddr   = paddr;
    r.exp_bit = exp_bit;
    r.exp_cnt = exp_cnt;
    r.data    = '0;
    if (op == OP_VRF) r.data = vrf_pattern(vidx, vpos);
    // Expected line keeps old contents where sel is low
    if (op == OP_LINE) begin
      r.data = merge_bytes(fill_line(paddr[PADDR_W-1:BANK_LSB]), vrf_pattern(vidx, vpos), strb);
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Committed stores and hazards
    add_row("t1_vrf_r1",     OP_VRF,    0,  1, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t1_vrf_r2",     OP_VRF,    0,  2, 1, 16'h0000, 32'h0,    0, 0);
    add_row("t1_alloc_a",    OP_ALLOC,  1,  1, 0, 16'hFFFF, 32'h1000, 0, 0);
    add_row("t1_alloc_b",    OP_ALLOC,  2,  2, 1, 16'h0F0F, 32'h1010, 0, 0);
    add_row("t1_haz_young",  OP_LOAD,   3,  0, 0, 16'h0000, 32'h1000, 1, 0);
    add_row("t1_haz_old",    OP_LOAD,   1,  0, 0, 16'h0000, 32'h1010, 0, 0);
    add_row("t1_haz_other",  OP_LOAD,   3,  0, 0, 16'h0000, 32'h1020, 0, 0);
    add_row("t1_commit_a",   OP_COMMIT, 1,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t1_commit_b",   OP_COMMIT, 2,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t1_drain",      OP_DRAIN,  0,  0, 0, 16'h0000, 32'h0,    0, 2);
    add_row("t1_line_a",     OP_LINE,   0,  1, 0, 16'hFFFF, 32'h1000, 0, 1);
    add_row("t1_line_b",     OP_LINE,   0,  2, 1, 16'h0F0F, 32'h1010, 0, 1);
    add_row("t1_haz_gone",   OP_LOAD,   3,  0, 0, 16'h0000, 32'h1000, 0, 0);
    // Commit flush
    add_row("t2_vrf_r3",     OP_VRF,    0,  3, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t2_alloc_a",    OP_ALLOC,  3,  3, 0, 16'hFFFF, 32'h2000, 0, 0);
    add_row("t2_alloc_b",    OP_ALLOC,  4,  3, 0, 16'hFF00, 32'h2010, 0, 0);
    add_row("t2_flush",      OP_CFLUSH, 3,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t2_commit_b",   OP_COMMIT, 4,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t2_drain",      OP_DRAIN,  0,  0, 0, 16'h0000, 32'h0,    0, 2);
    add_row("t2_line_a",     OP_LINE,   0,  0, 0, 16'h0000, 32'h2000, 0, 0);
    add_row("t2_line_b",     OP_LINE,   0,  0, 0, 16'h0000, 32'h2010, 0, 0);
    // Branch flush
    add_row("t3_vrf_r4",     OP_VRF,    0,  4, 1, 16'h0000, 32'h0,    0, 0);
    add_row("t3_alloc_a",    OP_ALLOC,  5,  4, 1, 16'h00FF, 32'h3000, 0, 0);
    add_row("t3_alloc_b",    OP_ALLOC,  6,  4, 1, 16'hFFFF, 32'h3010, 0, 0);
    add_row("t3_alloc_c",    OP_ALLOC,  7,  4, 1, 16'hFFFF, 32'h3020, 0, 0);
    add_row("t3_branch",     OP_BFLUSH, 5,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t3_commit_a",   OP_COMMIT, 5,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t3_commit_b",   OP_COMMIT, 6,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t3_commit_c",   OP_COMMIT, 7,  0, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t3_drain",      OP_DRAIN,  0,  0, 0, 16'h0000, 32'h0,    0, 3);
    add_row("t3_line_a",     OP_LINE,   0,  4, 1, 16'h00FF, 32'h3000, 0, 1);
    add_row("t3_line_b",     OP_LINE,   0,  0, 0, 16'h0000, 32'h3010, 0, 0);
    add_row("t3_line_c",     OP_LINE,   0,  0, 0, 16'h0000, 32'h3020, 0, 0);
    // Full bank and back-pressure
    add_row("t4_vrf_r5",     OP_VRF,    0,  5, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t4_vrf_r6",     OP_VRF,    0,  6, 1, 16'h0000, 32'h0,    0, 0);
    add_row("t4_vrf_r7",     OP_VRF,    0,  7, 0, 16'h0000, 32'h0,    0, 0);
    add_row("t4_vrf_r0",     OP_VRF,    0,  0, 1, 16'h0000, 32'h0,    0, 0);
    add_row("t4_alloc_a",    OP_ALLOC,  8,  5, 0, 16'hFFFF, 32'h4000, 0, 0);
    add_row("t4_alloc_b",    OP_ALLOC,  9,  6, 1, 16'hF00F, 32'h4020, 0, 0);
    add_row("t4_alloc_c",    OP_ALLOC,  10, 7, 0, 16'h0FF0, 32'h4040, 0, 0);
    add_row("t4_alloc_d",    OP_ALLOC,  11, 0, 1, 16'h8001, 32'h4060, 0, 0);
    add_row("t4_ready_full", OP_READY,  0,  0, 0, 16'h0000, 32'h4080, 0, 0);
    add_row("t4_ready_free", OP_READY,  0,  0, 0, 16'h0000, 32'h4090, 1, 0);
    add_row("t4_alloc_e",    OP_ALLOC,  12, 5, 0, 16'h3C3C, 32'h4090, 0, 0);
    add_row("t4_haz_young",  OP_LOAD,   13, 0, 0, 16'h0000, 32'h4040, 1, 0);
    add_row("t4_haz_old",    OP_LOAD,   9,  0, 0, 16'h0000, 32'h4040, 0, 0);
    for (int id = 8; id <= 12; id++) begin
      add_row($sformatf("t4_commit_%0d", id), OP_COMMIT, id, 0, 0, 16'h0, 32'h0, 0, 0);
    end
    add_row("t4_drain",      OP_DRAIN,  0,  0, 0, 16'h0000, 32'h0,    0, 8);
    add_row("t4_line_a",     OP_LINE,   0,  5, 0, 16'hFFFF, 32'h4000, 0, 1);
    add_row("t4_line_b",     OP_LINE,   0,  6, 1, 16'hF00F, 32'h4020, 0, 1);
    add_row("t4_line_c",     OP_LINE,   0,  7, 0, 16'h0FF0, 32'h4040, 0, 1);
    add_row("t4_line_d",     OP_LINE,   0,  0, 1, 16'h8001, 32'h4060, 0, 1);
    add_row("t4_line_e",     OP_LINE,   0,  5, 0, 16'h3C3C, 32'h4090, 0, 1);
    add_row("t4_haz_gone",   OP_LOAD,   13, 0, 0, 16'h0000, 32'h4040, 0, 0);
    add_row("t4_ready_back", OP_READY,  0,  0, 0, 16'h0000, 32'h4080, 1, 0);
  endtask

  // ------------------------------------------------------------------
  // Row execution
  // ------------------------------------------------------------------
  task automatic tick();
    @(posedge i_clk);
    #1;
  endtask

  task automatic wait_alloc_accept(string name);
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_alloc_ready) begin
      if (n == TIMEOUT) report_fail($sformatf("%s: allocation was never accepted", name));
      n++;
      @(negedge i_clk);
    end
  endtask

  task automatic wait_drain(string name, int exp_cnt);
    int n;
    n = 0;
    while (wr_total < exp_cnt || o_wb_cyc) begin
      if (n == TIMEOUT) report_fail($sformatf("%s: stores did not drain in time", name));
      n++;
      @(negedge i_clk);
    end
    repeat (QUIET) @(posedge i_clk);
  endtask

  task automatic run_row(row_t r);
    logic [WB_ADR_W-1:0] adr;
    adr = r.paddr[PADDR_W-1:BANK_LSB];
    case (r.op)
      OP_VRF: begin
        tick();
        i_vrf_we   = 1'b1;
        i_vrf_idx  = r.vidx;
        i_vrf_pos  = r.vpos;
        i_vrf_data = r.data;
        tick();
        i_vrf_we   = 1'b0;
      end
      OP_ALLOC: begin
        tick();
        i_alloc_valid   = 1'b1;
        i_alloc_cmt_id  = r.id;
        i_alloc_vs3_idx = r.vidx;
        i_alloc_vs3_pos = r.vpos;
        i_alloc_strb    = r.strb;
        i_alloc_paddr   = r.paddr;
        wait_alloc_accept(r.name);
        tick();
        i_alloc_valid   = 1'b0;
      end
      OP_COMMIT, OP_CFLUSH: begin
        tick();
        i_commit_valid = 1'b1;
        i_commit_id    = r.id;
        i_commit_flush = (r.op == OP_CFLUSH);
        tick();
        i_commit_valid = 1'b0;
        i_commit_flush = 1'b0;
      end
      OP_BFLUSH: begin
        tick();
        i_br_valid = 1'b1;
        i_br_id    = r.id;
        tick();
        i_br_valid = 1'b0;
      end
      OP_LOAD: begin
        tick();
        i_ld_valid = 1'b1;
        i_ld_id    = r.id;
        i_ld_paddr = r.paddr;
        @(negedge i_clk);
        check_haz(r.name, r.exp_bit, o_ld_haz);
        tick();
        i_ld_valid = 1'b0;
      end
      OP_READY: begin
        tick();
        i_alloc_paddr = r.paddr;   // Ready follows the target bank
        @(negedge i_clk);
        check_ready(r.name, r.exp_bit, o_alloc_ready);
      end
      OP_DRAIN: begin
        wait_drain(r.name, r.exp_cnt);
        check_count(r.name, r.exp_cnt, wr_total);
      end
      default: begin
        check_line(r.name, r.data, read_line(adr));
        check_count(r.name, r.exp_cnt, count_of(adr));
      end
    endcase
  endtask

  initial begin : main
    int n;
    i_alloc_valid   = 1'b0;
    i_alloc_cmt_id  = '0;
    i_alloc_vs3_idx = '0;
    i_alloc_vs3_pos = '0;
    i_alloc_strb    = '0;
    i_alloc_paddr   = '0;
    i_commit_valid  = 1'b0;
    i_commit_id     = '0;
    i_commit_flush  = 1'b0;
    i_br_valid      = 1'b0;
    i_br_id         = '0;
    i_vrf_we        = 1'b0;
    i_vrf_idx       = '0;
    i_vrf_pos       = '0;
    i_vrf_data      = '0;
    i_ld_valid      = 1'b0;
    i_ld_id         = '0;
    i_ld_paddr      = '0;
    build_table();

    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    check_ready("reset_ready", 1'b0, o_alloc_ready);
    check_haz("reset_haz", 1'b0, o_ld_haz);
    if (o_wb_cyc !== 1'b0 || o_wb_stb !== 1'b0) begin
      report_fail("Wishbone cycle is active during reset");
    end

    n = 0;
    while (!i_reset_n || !o_alloc_ready) begin
      if (n == TIMEOUT) report_fail("Queue did not become ready after reset");
      n++;
      @(negedge i_clk);
    end

    foreach (rows[i]) run_row(rows[i]);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/vstq_pkg.sv
common/vstq_ifs.sv
source/rr_select.sv
source/freelist_oh.sv
source/vec_regfile.sv
vstq/vstq_bank.sv
vstq/vstq.sv
source/vstq_subsystem.sv
test/tb_clkgen.sv
test/tb_vstq.sv

// File: Bender.yml
package:
  name: vstq

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/vstq_pkg.sv
      - common/vstq_ifs.sv
      - source/rr_select.sv
      - source/freelist_oh.sv
      - source/vec_regfile.sv
      - vstq/vstq_bank.sv
      - vstq/vstq.sv
      - source/vstq_subsystem.sv
  - target: test
    files:
      - test/tb_clkgen.sv
      - test/tb_vstq.sv
